// File: axi_iso_pkg.sv
// AXI-Lite isolator widths, field types, channel structs, isolation constants and FSM states
package axi_iso_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // Saturation point of the per-channel outstanding counters
  localparam int MAX_OUTSTANDING = 15;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [2:0]        prot_t;
  typedef logic [1:0]        resp_t;
  typedef logic [3:0]        count_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Response and read data returned for transactions answered during isolation
  localparam resp_t ISOLATE_RESP  = RESP_SLVERR;
  localparam data_t ISOLATE_RDATA = '0;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_req_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_req_t;

  typedef struct packed {
    resp_t resp;
  } b_rsp_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_rsp_t;

  typedef enum logic [1:0] {
    ST_CONNECTED,
    ST_HOLD,
    ST_ISOLATED
  } iso_state_t;

endpackage

// File: axi_iso_req_gate.sv
// Request gate that forwards, holds off or swallows upstream AW, W and AR requests
`timescale 1ns/1ps

module axi_iso_req_gate
  import axi_iso_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    hold,
  input  logic    isolated,
  input  logic    aw_full,
  input  logic    ar_full,
  input  aw_req_t up_aw,
  input  logic    up_awvalid,
  output logic    up_awready,
  input  w_req_t  up_w,
  input  logic    up_wvalid,
  output logic    up_wready,
  input  ar_req_t up_ar,
  input  logic    up_arvalid,
  output logic    up_arready,
  output aw_req_t dn_aw,
  output logic    dn_awvalid,
  input  logic    dn_awready,
  output w_req_t  dn_w,
  output logic    dn_wvalid,
  input  logic    dn_wready,
  output ar_req_t dn_ar,
  output logic    dn_arvalid,
  input  logic    dn_arready,
  output logic    aw_fire,
  output logic    ar_fire
);

  // Downstream may take AW and W in different cycles, so each half is tracked
  logic aw_done;
  logic w_done;
  logic wr_partial;
  logic wr_fwd;
  logic wr_take;

  assign wr_partial = aw_done || w_done;

  // A write with one half already taken downstream is finished even during hold
  assign wr_fwd = up_awvalid && up_wvalid && !isolated &&
                  (wr_partial || (!hold && !aw_full));

  assign dn_awvalid = wr_fwd && !aw_done;
  assign dn_wvalid  = wr_fwd && !w_done;
  assign dn_aw      = up_aw;
  assign dn_w       = up_w;

  always_comb begin
    if (isolated) begin
      // Swallowed here, the response generator answers it later
      wr_take = up_awvalid && up_wvalid && !aw_full;
    end else begin
      wr_take = wr_fwd && (aw_done || dn_awready) && (w_done || dn_wready);
    end
  end

  assign up_awready = wr_take;
  assign up_wready  = wr_take;
  assign aw_fire    = wr_take;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (isolated || wr_take) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (dn_awvalid && dn_awready) begin
        aw_done <= 1'b1;
      end
      if (dn_wvalid && dn_wready) begin
        w_done <= 1'b1;
      end
    end
  end

  // Read path needs no pairing
  assign dn_ar      = up_ar;
  assign dn_arvalid = up_arvalid && !hold && !isolated && !ar_full;
  assign up_arready = !hold && !ar_full && (isolated || dn_arready);
  assign ar_fire    = up_arvalid && up_arready;

endmodule

// File: axi_iso_ctrl.sv
// Isolation FSM with write and read outstanding counters and the isolate_done flag
`timescale 1ns/1ps

module axi_iso_ctrl
  import axi_iso_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic isolate_req,
  output logic isolate_done,
  output logic hold,
  output logic isolated,
  input  logic aw_fire,
  input  logic ar_fire,
  input  logic b_push,
  input  logic r_push,
  output logic aw_full,
  output logic ar_full,
  output logic gen_b,
  output logic gen_r
);

  iso_state_t state;
  iso_state_t state_next;
  count_t     wr_cnt;
  count_t     rd_cnt;
  logic       drained;
  logic       done_next;

  // Accepted request minus response pushed upstream, both may land together
  function automatic count_t count_step(count_t cnt, logic inc, logic dec);
    count_t res;
    res = cnt;
    if (inc && !dec) begin
      res = cnt + count_t'(1);
    end else if (dec && !inc) begin
      res = cnt - count_t'(1);
    end
    return res;
  endfunction

  always_comb begin
    state_next = state;
    case (state)
      ST_CONNECTED: begin
        if (isolate_req) begin
          state_next = ST_HOLD;
        end
      end
      // One cycle with all upstream readys low before the switch
      ST_HOLD: begin
        state_next = ST_ISOLATED;
      end
      ST_ISOLATED: begin
        if (!isolate_req) begin
          state_next = ST_CONNECTED;
        end
      end
      default: begin
        state_next = ST_CONNECTED;
      end
    endcase
  end

  assign hold     = (state == ST_HOLD);
  assign isolated = (state == ST_ISOLATED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_CONNECTED;
      wr_cnt <= '0;
      rd_cnt <= '0;
    end else begin
      state  <= state_next;
      wr_cnt <= count_step(wr_cnt, aw_fire, b_push);
      rd_cnt <= count_step(rd_cnt, ar_fire, r_push);
    end
  end

  // Counters stop accepting at the top instead of wrapping
  assign aw_full = (wr_cnt == count_t'(MAX_OUTSTANDING));
  assign ar_full = (rd_cnt == count_t'(MAX_OUTSTANDING));

  assign gen_b = isolated && (wr_cnt != '0);
  assign gen_r = isolated && (rd_cnt != '0);

  // Once raised, done stays up until the request is released
  assign drained   = isolated && (wr_cnt == '0) && (rd_cnt == '0);
  assign done_next = isolate_req && (isolate_done || drained);

  always_ff @(posedge clk) begin
    if (rst) begin
      isolate_done <= 1'b0;
    end else begin
      isolate_done <= done_next;
    end
  end

endmodule

// File: axi_iso_resp_gen.sv
// Response selection between downstream and generated responses, with upstream B and R registers
`timescale 1ns/1ps

module axi_iso_resp_gen
  import axi_iso_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   isolated,
  input  logic   gen_b,
  input  logic   gen_r,
  input  b_rsp_t dn_b,
  input  logic   dn_bvalid,
  output logic   dn_bready,
  input  r_rsp_t dn_r,
  input  logic   dn_rvalid,
  output logic   dn_rready,
  output b_rsp_t up_b,
  output logic   up_bvalid,
  input  logic   up_bready,
  output r_rsp_t up_r,
  output logic   up_rvalid,
  input  logic   up_rready,
  output logic   b_push,
  output logic   r_push
);

  b_rsp_t b_in;
  logic   b_in_valid;
  logic   b_in_ready;
  r_rsp_t r_in;
  logic   r_in_valid;
  logic   r_in_ready;

  // Source select, downstream responses are dropped while isolated
  always_comb begin
    b_in = dn_b;
    r_in = dn_r;
    if (isolated) begin
      b_in.resp = ISOLATE_RESP;
      r_in.resp = ISOLATE_RESP;
      r_in.data = ISOLATE_RDATA;
    end
  end

  assign b_in_valid = isolated ? gen_b : dn_bvalid;
  assign r_in_valid = isolated ? gen_r : dn_rvalid;

  // Register has space when empty or when its entry leaves this cycle
  assign b_in_ready = !up_bvalid || up_bready;
  assign r_in_ready = !up_rvalid || up_rready;

  assign dn_bready = isolated || b_in_ready;
  assign dn_rready = isolated || r_in_ready;

  assign b_push = b_in_valid && b_in_ready;
  assign r_push = r_in_valid && r_in_ready;

  // Write response register
  always_ff @(posedge clk) begin
    if (rst) begin
      up_bvalid <= 1'b0;
    end else if (b_in_ready) begin
      up_bvalid <= b_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (b_push) begin
      up_b <= b_in;
    end
  end

  // Read response register
  always_ff @(posedge clk) begin
    if (rst) begin
      up_rvalid <= 1'b0;
    end else if (r_in_ready) begin
      up_rvalid <= r_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (r_push) begin
      up_r <= r_in;
    end
  end

endmodule

// File: axi_lite_isolate_sub.sv
// Top level of the AXI-Lite subordinate isolator, joining request gate, control and responses
`timescale 1ns/1ps

module axi_lite_isolate_sub
  import axi_iso_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    isolate_req,
  output logic    isolate_done,
  input  aw_req_t up_aw,
  input  logic    up_awvalid,
  output logic    up_awready,
  input  w_req_t  up_w,
  input  logic    up_wvalid,
  output logic    up_wready,
  input  ar_req_t up_ar,
  input  logic    up_arvalid,
  output logic    up_arready,
  output b_rsp_t  up_b,
  output logic    up_bvalid,
  input  logic    up_bready,
  output r_rsp_t  up_r,
  output logic    up_rvalid,
  input  logic    up_rready,
  output aw_req_t dn_aw,
  output logic    dn_awvalid,
  input  logic    dn_awready,
  output w_req_t  dn_w,
  output logic    dn_wvalid,
  input  logic    dn_wready,
  output ar_req_t dn_ar,
  output logic    dn_arvalid,
  input  logic    dn_arready,
  input  b_rsp_t  dn_b,
  input  logic    dn_bvalid,
  output logic    dn_bready,
  input  r_rsp_t  dn_r,
  input  logic    dn_rvalid,
  output logic    dn_rready
);

  logic hold;
  logic isolated;
  logic aw_full;
  logic ar_full;
  logic aw_fire;
  logic ar_fire;
  logic gen_b;
  logic gen_r;
  logic b_push;
  logic r_push;

  axi_iso_req_gate u_req_gate (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .isolated   (isolated),
    .aw_full    (aw_full),
    .ar_full    (ar_full),
    .up_aw      (up_aw),
    .up_awvalid (up_awvalid),
    .up_awready (up_awready),
    .up_w       (up_w),
    .up_wvalid  (up_wvalid),
    .up_wready  (up_wready),
    .up_ar      (up_ar),
    .up_arvalid (up_arvalid),
    .up_arready (up_arready),
    .dn_aw      (dn_aw),
    .dn_awvalid (dn_awvalid),
    .dn_awready (dn_awready),
    .dn_w       (dn_w),
    .dn_wvalid  (dn_wvalid),
    .dn_wready  (dn_wready),
    .dn_ar      (dn_ar),
    .dn_arvalid (dn_arvalid),
    .dn_arready (dn_arready),
    .aw_fire    (aw_fire),
    .ar_fire    (ar_fire)
  );

  axi_iso_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .isolate_req  (isolate_req),
    .isolate_done (isolate_done),
    .hold         (hold),
    .isolated     (isolated),
    .aw_fire      (aw_fire),
    .ar_fire      (ar_fire),
    .b_push       (b_push),
    .r_push       (r_push),
    .aw_full      (aw_full),
    .ar_full      (ar_full),
    .gen_b        (gen_b),
    .gen_r        (gen_r)
  );

  axi_iso_resp_gen u_resp_gen (
    .clk       (clk),
    .rst       (rst),
    .isolated  (isolated),
    .gen_b     (gen_b),
    .gen_r     (gen_r),
    .dn_b      (dn_b),
    .dn_bvalid (dn_bvalid),
    .dn_bready (dn_bready),
    .dn_r      (dn_r),
    .dn_rvalid (dn_rvalid),
    .dn_rready (dn_rready),
    .up_b      (up_b),
    .up_bvalid (up_bvalid),
    .up_bready (up_bready),
    .up_r      (up_r),
    .up_rvalid (up_rvalid),
    .up_rready (up_rready),
    .b_push    (b_push),
    .r_push    (r_push)
  );

endmodule

// File: tb_axi_lite_isolate_sub.sv
// Testbench for the AXI-Lite isolator with downstream memory model, stimulus table and checks
`timescale 1ns/1ps

module tb_axi_lite_isolate_sub
  import axi_iso_pkg::*;
();

  typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_ISO_ON,
    OP_ISO_OFF,
    OP_STUCK
  } op_t;

  typedef struct packed {
    op_t   op;
    addr_t addr;
    data_t data;
    strb_t strb;
    resp_t exp_resp;
    data_t exp_data;
  } row_t;

  localparam int NUM_ROWS       = 16;
  localparam int TIMEOUT_CYCLES = 200 * NUM_ROWS;

  // Protection value carried by every request, seen again on the downstream side
  localparam prot_t REQ_PROT = 3'b101;

  logic clk;
  logic rst;
  logic isolate_req;
  logic isolate_done;
  aw_req_t up_aw;
  logic up_awvalid;
  logic up_awready;
  w_req_t up_w;
  logic up_wvalid;
  logic up_wready;
  ar_req_t up_ar;
  logic up_arvalid;
  logic up_arready;
  b_rsp_t up_b;
  logic up_bvalid;
  logic up_bready = 1'b0;
  r_rsp_t up_r;
  logic up_rvalid;
  logic up_rready = 1'b0;
  aw_req_t dn_aw;
  logic dn_awvalid;
  logic dn_awready;
  w_req_t dn_w;
  logic dn_wvalid;
  logic dn_wready;
  ar_req_t dn_ar;
  logic dn_arvalid;
  logic dn_arready;
  b_rsp_t dn_b = '0;
  logic dn_bvalid = 1'b0;
  logic dn_bready;
  r_rsp_t dn_r = '0;
  logic dn_rvalid = 1'b0;
  logic dn_rready;

  row_t  rows [NUM_ROWS];
  string names [NUM_ROWS];
  int    row_cnt = 0;

  integer seed = 32'h156d;
  integer rnd;
  int unsigned cycles = 0;
  logic stuck = 1'b0;
  logic iso_watch = 1'b0;
  logic b_wait = 1'b0;
  logic r_wait = 1'b0;
  b_rsp_t b_last;
  r_rsp_t r_last;

  // Downstream model state
  data_t mem [16];
  logic [1:0] b_dly = '0;
  logic [1:0] r_dly = '0;
  addr_t rd_addr = '0;

  assign dn_awready = 1'b1;
  assign dn_wready  = 1'b1;
  assign dn_arready = 1'b1;

  axi_lite_isolate_sub u_dut (
    .clk(clk), .rst(rst), .isolate_req(isolate_req), .isolate_done(isolate_done),
    .up_aw(up_aw), .up_awvalid(up_awvalid), .up_awready(up_awready),
    .up_w(up_w), .up_wvalid(up_wvalid), .up_wready(up_wready),
    .up_ar(up_ar), .up_arvalid(up_arvalid), .up_arready(up_arready),
    .up_b(up_b), .up_bvalid(up_bvalid), .up_bready(up_bready),
    .up_r(up_r), .up_rvalid(up_rvalid), .up_rready(up_rready),
    .dn_aw(dn_aw), .dn_awvalid(dn_awvalid), .dn_awready(dn_awready),
    .dn_w(dn_w), .dn_wvalid(dn_wvalid), .dn_wready(dn_wready),
    .dn_ar(dn_ar), .dn_arvalid(dn_arvalid), .dn_arready(dn_arready),
    .dn_b(dn_b), .dn_bvalid(dn_bvalid), .dn_bready(dn_bready),
    .dn_r(dn_r), .dn_rvalid(dn_rvalid), .dn_rready(dn_rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic add_row(input op_t op, input addr_t addr, input data_t data, input strb_t strb,
                         input resp_t exp_resp, input data_t exp_data, input string name);
    rows[row_cnt]  = '{op: op, addr: addr, data: data, strb: strb,
                       exp_resp: exp_resp, exp_data: exp_data};
    names[row_cnt] = name;
    row_cnt++;
  endtask

  task automatic issue_write(input addr_t addr, input data_t data, input strb_t strb);
    @(posedge clk);
    up_aw      <= '{addr: addr, prot: REQ_PROT};
    up_w       <= '{data: data, strb: strb};
    up_awvalid <= 1'b1;
    up_wvalid  <= 1'b1;
    do begin
      @(posedge clk);
    end while (!(up_awready && up_wready));
    up_awvalid <= 1'b0;
    up_wvalid  <= 1'b0;
  endtask

  task automatic issue_read(input addr_t addr);
    @(posedge clk);
    up_ar      <= '{addr: addr, prot: REQ_PROT};
    up_arvalid <= 1'b1;
    do begin
      @(posedge clk);
    end while (!up_arready);
    up_arvalid <= 1'b0;
  endtask

  task automatic wait_b(output b_rsp_t rsp);
    do begin
      @(posedge clk);
    end while (!(up_bvalid && up_bready));
    rsp = up_b;
  endtask

  task automatic wait_r(output r_rsp_t rsp);
    do begin
      @(posedge clk);
    end while (!(up_rvalid && up_rready));
    rsp = up_r;
  endtask

  // Memory answers OKAY two cycles after each request unless stuck
  always @(posedge clk) begin
    if (rst) begin
      b_dly     <= '0;
      r_dly     <= '0;
      dn_bvalid <= 1'b0;
      dn_rvalid <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= {16'hface, 12'h000, i[3:0]};
      end
    end else begin
      b_dly <= {b_dly[0], dn_awvalid && dn_wvalid && !stuck};
      r_dly <= {r_dly[0], dn_arvalid && !stuck};
      if (dn_awvalid && dn_wvalid) begin
        check_value("aw_prot", 64'(REQ_PROT), 64'(dn_aw.prot));
        for (int i = 0; i < STRB_W; i++) begin
          if (dn_w.strb[i]) begin
            mem[dn_aw.addr[5:2]][8*i +: 8] <= dn_w.data[8*i +: 8];
          end
        end
      end
      if (dn_arvalid) begin
        check_value("ar_prot", 64'(REQ_PROT), 64'(dn_ar.prot));
        rd_addr <= dn_ar.addr;
      end
      if (b_dly[1]) begin
        dn_bvalid   <= 1'b1;
        dn_b.resp   <= RESP_OKAY;
      end else if (dn_bready) begin
        dn_bvalid <= 1'b0;
      end
      if (r_dly[1]) begin
        dn_rvalid <= 1'b1;
        dn_r.resp <= RESP_OKAY;
        dn_r.data <= mem[rd_addr[5:2]];
      end else if (dn_rready) begin
        dn_rvalid <= 1'b0;
      end
    end
  end

  // Random upstream back-pressure on B and R
  always @(posedge clk) begin
    rnd = $random(seed);
    up_bready <= rnd[0];
    up_rready <= rnd[1];
  end

  // Response registers hold while stalled and downstream stays quiet while isolated
  always @(posedge clk) begin
    if (rst) begin
      b_wait <= 1'b0;
      r_wait <= 1'b0;
    end else begin
      if (iso_watch) begin
        check_value("dn_valid_isolated", 64'd0, 64'({dn_awvalid, dn_wvalid, dn_arvalid}));
      end
      if (b_wait) begin
        check_value("b_stable", 64'({1'b1, b_last}), 64'({up_bvalid, up_b}));
      end
      if (r_wait) begin
        check_value("r_stable", 64'({1'b1, r_last}), 64'({up_rvalid, up_r}));
      end
      b_wait <= up_bvalid && !up_bready;
      r_wait <= up_rvalid && !up_rready;
      b_last <= up_b;
      r_last <= up_r;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycles);
      $display("TEST FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  initial begin
    b_rsp_t b;
    r_rsp_t r;
    logic   rd_pending;
    rst         = 1'b1;
    isolate_req = 1'b0;
    up_aw       = '0;
    up_awvalid  = 1'b0;
    up_w        = '0;
    up_wvalid   = 1'b0;
    up_ar       = '0;
    up_arvalid  = 1'b0;
    rd_pending  = 1'b0;

    add_row(OP_WR, 12'h010, 32'hdeadbeef, 4'hf, RESP_OKAY, 32'h0, "wr_basic");
    add_row(OP_RD, 12'h010, 32'h0, 4'h0, RESP_OKAY, 32'hdeadbeef, "rd_basic");
    add_row(OP_WR, 12'h024, 32'h0badf00d, 4'hf, RESP_OKAY, 32'h0, "wr_second");
    add_row(OP_RD, 12'h024, 32'h0, 4'h0, RESP_OKAY, 32'h0badf00d, "rd_second");
    add_row(OP_STUCK, 12'h0, 32'h1, 4'h0, RESP_OKAY, 32'h0, "stuck_on");
    add_row(OP_RD, 12'h010, 32'h0, 4'h0, RESP_OKAY, 32'h0, "rd_stuck_issue");
    add_row(OP_ISO_ON, 12'h0, 32'h0, 4'h0, RESP_SLVERR, 32'h0, "iso_pending_rd");
    add_row(OP_WR, 12'h010, 32'h55555555, 4'hf, RESP_SLVERR, 32'h0, "wr_isolated");
    add_row(OP_RD, 12'h024, 32'h0, 4'h0, RESP_SLVERR, 32'h0, "rd_isolated");
    add_row(OP_ISO_OFF, 12'h0, 32'h0, 4'h0, RESP_OKAY, 32'h0, "iso_release");
    add_row(OP_STUCK, 12'h0, 32'h0, 4'h0, RESP_OKAY, 32'h0, "stuck_off");
    // Swallowed write during isolation must leave memory untouched
    add_row(OP_RD, 12'h010, 32'h0, 4'h0, RESP_OKAY, 32'hdeadbeef, "rd_after_release");
    add_row(OP_WR, 12'h010, 32'h11223344, 4'h3, RESP_OKAY, 32'h0, "wr_partial_lo");
    add_row(OP_RD, 12'h010, 32'h0, 4'h0, RESP_OKAY, 32'hdead3344, "rd_partial_lo");
    add_row(OP_WR, 12'h024, 32'haabbccdd, 4'hc, RESP_OKAY, 32'h0, "wr_partial_hi");
    add_row(OP_RD, 12'h024, 32'h0, 4'h0, RESP_OKAY, 32'haabbf00d, "rd_partial_hi");

    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      case (rows[i].op)
        OP_WR: begin
          issue_write(rows[i].addr, rows[i].data, rows[i].strb);
          wait_b(b);
          check_value({names[i], " resp"}, 64'(rows[i].exp_resp), 64'(b.resp));
        end
        OP_RD: begin
          issue_read(rows[i].addr);
          // A stuck memory leaves the read open until isolation answers it
          if (stuck && !isolate_req) begin
            rd_pending = 1'b1;
          end else begin
            wait_r(r);
            check_value({names[i], " resp"}, 64'(rows[i].exp_resp), 64'(r.resp));
            check_value({names[i], " data"}, 64'(rows[i].exp_data), 64'(r.data));
          end
        end
        OP_ISO_ON: begin
          @(posedge clk);
          isolate_req <= 1'b1;
          if (rd_pending) begin
            wait_r(r);
            check_value({names[i], " resp"}, 64'(rows[i].exp_resp), 64'(r.resp));
            check_value({names[i], " data"}, 64'(rows[i].exp_data), 64'(r.data));
            rd_pending = 1'b0;
          end
          while (!isolate_done) begin
            @(posedge clk);
          end
          iso_watch <= 1'b1;
        end
        OP_ISO_OFF: begin
          @(posedge clk);
          isolate_req <= 1'b0;
          iso_watch   <= 1'b0;
          @(posedge clk);
          check_value({names[i], " done_held"}, 64'd1, 64'(isolate_done));
          @(posedge clk);
          check_value({names[i], " done_fall"}, 64'd0, 64'(isolate_done));
        end
        OP_STUCK: begin
          @(posedge clk);
          stuck <= rows[i].data[0];
        end
        default: begin
          $display("Unknown operation in table row %0d", i);
          $display("TEST FAILED");
          $fatal(1, "bad table row");
        end
      endcase
    end

    @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

// File: project.f
axi_iso_pkg.sv
axi_iso_req_gate.sv
axi_iso_ctrl.sv
axi_iso_resp_gen.sv
axi_lite_isolate_sub.sv
tb_axi_lite_isolate_sub.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_axi_lite_isolate_sub \
  -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
